/* rtl/spi_clock_divider.sv */
// Half-period tick source; first tick comes SPI_HALF_PERIOD_CYCLES clocks after i_run rises
`timescale 1ns/10ps
`default_nettype none

`include "spi_macros.svh"

module spi_clock_divider (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_run,
	output logic o_tick
);

	localparam int unsigned cnt_w = $clog2(`SPI_HALF_PERIOD_CYCLES + 1);
	localparam logic [cnt_w-1:0] reload = cnt_w'(`SPI_HALF_PERIOD_CYCLES - 1);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (!i_run) begin
			// Held at zero between frames, fixed phase at every start
			cnt <= '0;
			o_tick <= 1'b0;
		end else begin
			// Zero means just started or just ticked, so reload
			cnt <= (cnt == '0) ? reload : cnt - 1'b1;
			o_tick <= (cnt == cnt_w'(1));
		end
	end

endmodule

`default_nettype wire

/* rtl/spi_command_regs.sv */
// Four-phase req/ack host side; host keeps i_req and tx bytes stable until o_ack, enable only gates new frames
`timescale 1ns/10ps
`default_nettype none

module spi_command_regs import spi_frame_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_enable,
	input wire logic i_req,
	input wire spi_byte_t i_tx_upper,
	input wire spi_byte_t i_tx_lower,
	output logic o_ack,
	output logic o_busy,
	output spi_byte_t o_rx_upper,
	output spi_byte_t o_rx_lower,
	spi_xfer_if.regs xfer
);

	logic busy_q;
	logic ack_q;
	logic start_q;
	logic accept;
	spi_frame_t tx_q;
	spi_byte_t rx_upper_q;
	spi_byte_t rx_lower_q;

	// New frame only when enabled, idle and the previous ack has been released
	assign accept = i_req && i_enable && !busy_q && !ack_q;

	// Handshake and busy flag
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			busy_q <= 1'b0;
			ack_q <= 1'b0;
			start_q <= 1'b0;
		end else begin
			// Busy rises with acceptance so start stays a single pulse
			start_q <= accept;
			if (accept) begin
				busy_q <= 1'b1;
			end else if (xfer.done) begin
				busy_q <= 1'b0;
			end
			// Ack held until the host drops its request
			if (xfer.done) begin
				ack_q <= 1'b1;
			end else if (!i_req) begin
				ack_q <= 1'b0;
			end
		end
	end

	// Transmit and receive holding registers
	always_ff @(posedge i_clock) begin
		if (accept) begin
			tx_q <= '{upper: i_tx_upper, lower: i_tx_lower};
		end
		if (xfer.done) begin
			rx_upper_q <= xfer.rx_frame.upper;
			rx_lower_q <= xfer.rx_frame.lower;
		end
	end

	assign xfer.start = start_q;
	assign xfer.tx_frame = tx_q;
	assign o_ack = ack_q;
	assign o_busy = busy_q;
	assign o_rx_upper = rx_upper_q;
	assign o_rx_lower = rx_lower_q;

endmodule

`default_nettype wire

/* rtl/spi_ctrl_pkg.sv */
// State encoding of the serial engine; states step only on divider ticks
`default_nettype none

package spi_ctrl_pkg;

	// Engine states
	// idle        CS high, waiting for start
	// setup       CS low, counting setup half periods
	// shift_low   SCLK low, next tick is a rising edge
	// shift_high  SCLK high, next tick is a falling edge
	// finish      last half period before CS rises
	typedef enum logic [2:0] {
		idle,
		setup,
		shift_low,
		shift_high,
		finish
	} spi_state_t;

endpackage

`default_nettype wire

/* rtl/spi_frame_pkg.sv */
// Payload types for the 16-bit register-access frame; upper byte goes out first on the wire
`default_nettype none

`include "spi_macros.svh"

package spi_frame_pkg;

	// One byte of the frame
	typedef logic [`SPI_BYTE_WIDTH-1:0] spi_byte_t;

	// Whole frame, upper byte in the MSBs
	// Upper usually holds the register address with R/W flag in bit 7
	// Lower holds write data, or read data on the way back
	typedef struct packed {
		spi_byte_t upper;
		spi_byte_t lower;
	} spi_frame_t;

endpackage

`default_nettype wire

/* rtl/spi_macros.svh */
// Frame constants for the SPI master; half period must be at least 2 clocks, setup halves below 32
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Bits in one byte of the device frame
`define SPI_BYTE_WIDTH 8

// System clocks per serial clock half period
// SCLK runs at i_clock / (2 * this value)
`define SPI_HALF_PERIOD_CYCLES 4

// Half periods with CS low before the first SCLK rise
// Covers the device chip-select setup time
`define SPI_CS_SETUP_HALVES 2

// One frame is an upper byte then a lower byte
`define SPI_FRAME_BITS (2 * `SPI_BYTE_WIDTH)

`endif

/* rtl/spi_master_top.sv */
// SPI master for a 16-bit register-access device, mode 0 only, whole design on i_clock
`timescale 1ns/10ps
`default_nettype none

module spi_master_top import spi_frame_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	// Host side
	input wire logic i_enable,
	input wire logic i_req,
	input wire spi_byte_t i_tx_upper,
	input wire spi_byte_t i_tx_lower,
	output logic o_ack,
	output logic o_busy,
	output spi_byte_t o_rx_upper,
	output spi_byte_t o_rx_lower,
	// Serial side
	input wire logic i_miso,
	output logic o_sclk,
	output logic o_mosi,
	output logic o_cs_n
);

	logic run;
	logic tick;

	// Start/done link between register block and engine
	spi_xfer_if xfer_if ();

	spi_command_regs command_regs_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable (i_enable),
		.i_req (i_req),
		.i_tx_upper (i_tx_upper),
		.i_tx_lower (i_tx_lower),
		.o_ack (o_ack),
		.o_busy (o_busy),
		.o_rx_upper (o_rx_upper),
		.o_rx_lower (o_rx_lower),
		.xfer (xfer_if.regs)
	);

	// Paces SCLK only while the engine holds run
	spi_clock_divider clock_divider_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_run (run),
		.o_tick (tick)
	);

	spi_shift_engine shift_engine_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_tick (tick),
		.i_miso (i_miso),
		.o_run (run),
		.o_sclk (o_sclk),
		.o_mosi (o_mosi),
		.o_cs_n (o_cs_n),
		.xfer (xfer_if.engine)
	);

endmodule

`default_nettype wire

/* rtl/spi_shift_engine.sv */
// Mode 0 frame engine, MSB first; start is ignored unless idle, one frame is 35 ticks from start to done
`timescale 1ns/10ps
`default_nettype none

`include "spi_macros.svh"

module spi_shift_engine import spi_frame_pkg::*; import spi_ctrl_pkg::*; (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_tick,
	input wire logic i_miso,
	output logic o_run,
	output logic o_sclk,
	output logic o_mosi,
	output logic o_cs_n,
	spi_xfer_if.engine xfer
);

	// Counter covers the setup ticks and both edges of every bit
	localparam int unsigned cnt_w = $clog2(`SPI_FRAME_BITS * 2);
	localparam logic [cnt_w-1:0] setup_last = cnt_w'(`SPI_CS_SETUP_HALVES - 1);
	localparam logic [cnt_w-1:0] shift_last = cnt_w'(`SPI_FRAME_BITS * 2 - 1);

	spi_state_t state;
	logic [cnt_w-1:0] half_cnt;
	logic run_q;
	logic cs_n_q;
	logic sclk_q;
	logic done_q;
	spi_frame_t tx_shift;
	spi_frame_t rx_shift;

	// Frame sequencing, CS, SCLK and transmit shift
	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state <= idle;
			half_cnt <= '0;
			run_q <= 1'b0;
			cs_n_q <= 1'b1;
			sclk_q <= 1'b0;
			done_q <= 1'b0;
			tx_shift <= '0;
		end else begin
			done_q <= 1'b0;
			case (state)
				idle: begin
					// CS drops right away, divider starts its first half period
					if (xfer.start) begin
						state <= setup;
						half_cnt <= '0;
						run_q <= 1'b1;
						cs_n_q <= 1'b0;
						tx_shift <= xfer.tx_frame;
					end
				end
				setup: begin
					if (i_tick) begin
						if (half_cnt == setup_last) begin
							half_cnt <= '0;
							state <= shift_low;
						end else begin
							half_cnt <= half_cnt + 1'b1;
						end
					end
				end
				shift_low: begin
					// Rising edge, device samples MOSI here
					if (i_tick) begin
						sclk_q <= 1'b1;
						half_cnt <= half_cnt + 1'b1;
						state <= shift_high;
					end
				end
				shift_high: begin
					// Falling edge, next bit onto MOSI
					if (i_tick) begin
						sclk_q <= 1'b0;
						tx_shift <= {tx_shift[`SPI_FRAME_BITS-2:0], 1'b0};
						if (half_cnt == shift_last) begin
							half_cnt <= '0;
							state <= finish;
						end else begin
							half_cnt <= half_cnt + 1'b1;
							state <= shift_low;
						end
					end
				end
				finish: begin
					// Hold half period after last fall, then release CS
					if (i_tick) begin
						cs_n_q <= 1'b1;
						run_q <= 1'b0;
						done_q <= 1'b1;
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// MISO captured on rising edges, ends up in natural bit order
	always_ff @(posedge i_clock) begin
		if (state == shift_low && i_tick) begin
			rx_shift <= {rx_shift[`SPI_FRAME_BITS-2:0], i_miso};
		end
	end

	assign o_run = run_q;
	assign o_cs_n = cs_n_q;
	assign o_sclk = sclk_q;
	// MSB of the shift register drives the line, first bit ready before first rise
	assign o_mosi = tx_shift[`SPI_FRAME_BITS-1];
	assign xfer.done = done_q;
	assign xfer.rx_frame = rx_shift;

endmodule

`default_nettype wire

/* rtl/spi_xfer_if.sv */
// Start/done link between command registers and shift engine; start and done are one-cycle pulses
`timescale 1ns/10ps
`default_nettype none

interface spi_xfer_if import spi_frame_pkg::*; ();

	// Request side, tx_frame held stable while start is high
	logic start;
	spi_frame_t tx_frame;

	// Completion side, rx_frame valid in the done cycle
	logic done;
	spi_frame_t rx_frame;

	// Register block launches frames and collects results
	modport regs (
		output start,
		output tx_frame,
		input done,
		input rx_frame
	);

	// Engine consumes the request and reports completion
	modport engine (
		input start,
		input tx_frame,
		output done,
		output rx_frame
	);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI master testbench with Verilator.
# The exit status is the simulator's, nonzero when the testbench fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f spi_master.f \
	--top-module spi_master_tb \
	-o spi_master_sim

./obj_dir/spi_master_sim

/* spi_master.f */
+incdir+rtl
rtl/spi_frame_pkg.sv
rtl/spi_ctrl_pkg.sv
rtl/spi_xfer_if.sv
rtl/spi_command_regs.sv
rtl/spi_clock_divider.sv
rtl/spi_shift_engine.sv
rtl/spi_master_top.sv
verif/spi_master_assertions.sv
verif/spi_master_tb.sv

/* verif/spi_master_assertions.sv */
// Protocol checks bound into the shift engine; inactive while reset is high
`timescale 1ns/10ps
`default_nettype none

module spi_master_assertions (
	input wire logic i_clock,
	input wire logic i_reset,
	input wire logic i_sclk,
	input wire logic i_cs_n,
	input wire logic i_done
);

	// No serial clock pulse outside a frame
	sclk_low_when_idle: assert property (@(posedge i_clock) disable iff (i_reset)
		i_cs_n |-> !i_sclk)
		else $error("sclk high while chip select is released");

	// Chip select only moves with the clock low
	cs_stable_while_sclk_high: assert property (@(posedge i_clock) disable iff (i_reset)
		i_sclk |=> $stable(i_cs_n))
		else $error("chip select changed while sclk was high");

	// Done marks the end of the frame
	done_with_cs_rise: assert property (@(posedge i_clock) disable iff (i_reset)
		i_done |-> $rose(i_cs_n))
		else $error("done pulsed without chip select rising");

endmodule

// Attached to every shift engine instance
bind spi_shift_engine spi_master_assertions assertions_i (
	.i_clock (i_clock),
	.i_reset (i_reset),
	.i_sclk (o_sclk),
	.i_cs_n (o_cs_n),
	.i_done (done_q)
);

`default_nettype wire

/* verif/spi_master_tb.sv */
// Directed testbench for spi_master_top; device model is mode 0, 16 bits, response preset per frame
`timescale 1ns/10ps
`default_nettype none

`include "spi_macros.svh"

module spi_master_tb;

	// Bound on every wait, well past one frame
	localparam int timeout_cycles = 4 * `SPI_FRAME_BITS * `SPI_HALF_PERIOD_CYCLES;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_enable;
	logic i_req;
	logic [`SPI_BYTE_WIDTH-1:0] i_tx_upper;
	logic [`SPI_BYTE_WIDTH-1:0] i_tx_lower;
	logic i_miso;
	logic o_ack;
	logic o_busy;
	logic [`SPI_BYTE_WIDTH-1:0] o_rx_upper;
	logic [`SPI_BYTE_WIDTH-1:0] o_rx_lower;
	logic o_sclk;
	logic o_mosi;
	logic o_cs_n;

	// Device side state
	logic [`SPI_FRAME_BITS-1:0] dev_resp;
	logic [`SPI_FRAME_BITS-1:0] dev_shift;
	logic [`SPI_FRAME_BITS-1:0] dev_rx;
	int rise_total;

	// 10 ns period
	always #5 i_clock = ~i_clock;

	spi_master_top dut_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable (i_enable),
		.i_req (i_req),
		.i_tx_upper (i_tx_upper),
		.i_tx_lower (i_tx_lower),
		.o_ack (o_ack),
		.o_busy (o_busy),
		.o_rx_upper (o_rx_upper),
		.o_rx_lower (o_rx_lower),
		.i_miso (i_miso),
		.o_sclk (o_sclk),
		.o_mosi (o_mosi),
		.o_cs_n (o_cs_n)
	);

	// Mode 0 device, one pass of the loop per frame
	initial begin
		i_miso = 1'b0;
		rise_total = 0;
		dev_rx = '0;
		forever begin
			@(negedge o_cs_n);
			// First response bit ready before the first rise
			dev_shift = dev_resp;
			i_miso <= dev_shift[`SPI_FRAME_BITS-1];
			while (!o_cs_n) begin
				@(o_sclk or o_cs_n);
				if (!o_cs_n && o_sclk) begin
					dev_rx = {dev_rx[`SPI_FRAME_BITS-2:0], o_mosi};
					rise_total = rise_total + 1;
				end else if (!o_cs_n) begin
					// Falling edge, next bit out
					dev_shift = dev_shift << 1;
					i_miso <= dev_shift[`SPI_FRAME_BITS-1];
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timed out after %0d cycles waiting for %s", timeout_cycles, what);
		$display("sim failed");
		$fatal(1);
	endtask

	// Host raises req with both bytes, device answer preset
	task automatic request_frame(input logic [15:0] tx, input logic [15:0] resp);
		dev_resp = resp;
		@(posedge i_clock);
		i_tx_upper <= tx[15:8];
		i_tx_lower <= tx[7:0];
		i_req <= 1'b1;
	endtask

	// Follows one frame to ack, checks it, then releases the handshake
	task automatic complete_frame(input logic [15:0] tx, input logic [15:0] resp);
		int n;
		int rises_before;
		rises_before = rise_total;
		n = 0;
		while (!o_busy) begin
			@(negedge i_clock);
			n++;
			if (n > timeout_cycles) report_timeout("o_busy to rise");
		end
		n = 0;
		while (!o_ack) begin
			check_equal("o_busy during frame", o_busy, 1);
			@(negedge i_clock);
			n++;
			if (n > timeout_cycles) report_timeout("o_ack to rise");
		end
		check_equal("o_busy at ack", o_busy, 0);
		check_equal("o_rx_upper", o_rx_upper, resp[15:8]);
		check_equal("o_rx_lower", o_rx_lower, resp[7:0]);
		check_equal("frame seen by device", dev_rx, tx);
		check_equal("sclk rising edges", rise_total - rises_before, `SPI_FRAME_BITS);
		// Request still held, ack stays and no new frame starts
		repeat (3) begin
			@(negedge i_clock);
			check_equal("o_ack while req held", o_ack, 1);
			check_equal("o_cs_n while req held", o_cs_n, 1);
		end
		@(posedge i_clock);
		i_req <= 1'b0;
		n = 0;
		while (o_ack) begin
			@(negedge i_clock);
			n++;
			if (n > timeout_cycles) report_timeout("o_ack to fall");
		end
		// Ack drops one clock after req is seen low
		check_equal("negedges until ack fall", n, 2);
	endtask

	task automatic test_reset_state();
		@(negedge i_clock);
		check_equal("o_cs_n after reset", o_cs_n, 1);
		check_equal("o_sclk after reset", o_sclk, 0);
		check_equal("o_ack after reset", o_ack, 0);
		check_equal("o_busy after reset", o_busy, 0);
	endtask

	task automatic test_single_frame();
		request_frame(16'h8A5C, 16'h3CE1);
		complete_frame(16'h8A5C, 16'h3CE1);
	endtask

	task automatic test_back_to_back();
		logic [31:0] rnd;
		rnd = 32'd58908;
		repeat (10) begin
			rnd = xorshift32(rnd);
			request_frame(rnd[15:0], rnd[31:16]);
			complete_frame(rnd[15:0], rnd[31:16]);
		end
	endtask

	// Disabled master ignores the request until enable returns
	task automatic test_enable_gate();
		@(posedge i_clock);
		i_enable <= 1'b0;
		request_frame(16'h1F2E, 16'hC4B7);
		repeat (timeout_cycles) begin
			@(negedge i_clock);
			check_equal("o_ack while disabled", o_ack, 0);
			check_equal("o_cs_n while disabled", o_cs_n, 1);
			check_equal("o_busy while disabled", o_busy, 0);
		end
		@(posedge i_clock);
		i_enable <= 1'b1;
		complete_frame(16'h1F2E, 16'hC4B7);
	endtask

	initial begin
		i_reset = 1'b1;
		i_enable = 1'b1;
		i_req = 1'b0;
		i_tx_upper = '0;
		i_tx_lower = '0;
		dev_resp = '0;
		repeat (3) @(posedge i_clock);
		i_reset <= 1'b0;
		test_reset_state();
		test_single_frame();
		test_back_to_back();
		test_enable_gate();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire
